//--- acc_1.f
+incdir+.
acc_pkg.sv
input_queue_controller.sv
output_queue_controller.sv
dsm_controller.sv
acc_user_1.sv
acc_1.sv
tb_clock_gen.sv
tb_acc_1.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_acc_1
FILELIST  := acc_1.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_acc_1.sv
`default_nettype none
`include "acc_defs.svh"

module tb_acc_1;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_W = `ACC_ADDR_WIDTH;
  localparam int TAG_W = `ACC_TAG_WIDTH;
  localparam int DATA_W = `ACC_DATA_WIDTH;
  localparam int NUM_IN = `ACC_NUM_IN_QUEUES;
  localparam int NUM_OUT = `ACC_NUM_OUT_QUEUES;
  localparam int RQ_W = TAG_W + ADDR_W;
  localparam int WR_W = DATA_W + ADDR_W + TAG_W;
  localparam int OUT_TAG = 2;
  localparam int STATUS_TIMEOUT = 5000;
  localparam int DRAIN_TIMEOUT = 500;

  typedef logic [DATA_W-1:0] word_t;

  logic clk;
  logic rst_n;
  logic start;
  acc_pkg::conf_kind_e conf_valid;
  logic [`ACC_CONF_WIDTH-1:0] conf;
  logic [NUM_IN-1:0] available_read;
  wire [NUM_IN-1:0] request_read;
  wire [RQ_W*NUM_IN-1:0] request_data;
  logic read_data_valid;
  logic [TAG_W-1:0] read_queue_id;
  logic [DATA_W-1:0] read_data;
  logic [NUM_OUT:0] available_write;
  wire [NUM_OUT:0] request_write;
  wire [WR_W*(NUM_OUT+1)-1:0] write_data;
  logic write_data_valid;
  logic [TAG_W-1:0] write_queue_id;

  integer seed = 86950;
  logic stall;
  int job_count;
  int in_base [NUM_IN];
  int out_base;
  int dsm_base;
  int rd_cnt [NUM_IN];
  int out_writes;
  int out_acks;
  int dsm_count;
  word_t dsm_data;
  logic [RQ_W-1:0] rd_q [$];
  int wr_q [$];

  tb_clock_gen #(
    .PERIOD_NS(40),
    .RESET_CYCLES(8)
  ) i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  acc_1 i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .start            (start),
    .conf_valid       (conf_valid),
    .conf             (conf),
    .available_read   (available_read),
    .request_read     (request_read),
    .request_data     (request_data),
    .read_data_valid  (read_data_valid),
    .read_queue_id    (read_queue_id),
    .read_data        (read_data),
    .available_write  (available_write),
    .request_write    (request_write),
    .write_data       (write_data),
    .write_data_valid (write_data_valid),
    .write_queue_id   (write_queue_id)
  );

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %0d ns %s: got %h, expected %h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_kind(input string name, input acc_pkg::conf_kind_e got,
                            input acc_pkg::conf_kind_e exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %0d ns %s: got %s, expected %s",
                               $time, name, got.name(), exp.name()));
    end
  endtask

  function automatic int draw(input int limit);
    draw = int'($unsigned($random(seed)) % limit);
  endfunction

  // each input queue has its own key, so a swapped queue shows up in the sums.
  function automatic word_t mem_word(input int qid, input int addr);
    word_t key;
    key = (qid == 0) ? 32'h1357_00a5 : 32'h2468_5a00;
    mem_word = word_t'(addr & 'hffff) ^ key;
  endfunction

  function automatic word_t expected_sum(input int idx);
    expected_sum = mem_word(0, in_base[0] + 4 * idx) + mem_word(1, in_base[1] + 4 * idx);
  endfunction

  function automatic word_t status_word(input int pushes, input int pops);
    status_word = word_t'((pushes << (DATA_W / 2)) | pops);
  endfunction

  // requests are sampled at the falling edge, responses driven 1 ns after the rising edge.
  initial begin : memory_model
    int rd_wait;
    int wr_wait;
    int tag;
    logic [RQ_W-1:0] req;
    logic [WR_W-1:0] wr;
    rd_wait = 0;
    wr_wait = 0;
    available_read = '0;
    available_write = '0;
    read_data_valid = 1'b0;
    read_queue_id = '0;
    read_data = '0;
    write_data_valid = 1'b0;
    write_queue_id = '0;
    forever begin
      @(negedge clk);
      for (int q = 0; q < NUM_IN; q++) begin
        if (request_read[q]) begin
          req = request_data[q*RQ_W +: RQ_W];
          if (!available_read[q]) report_failure("read request while memory was not available");
          check_word("request_data tag", word_t'(req[RQ_W-1 -: TAG_W]), word_t'(q));
          check_word("request_data addr", word_t'(req[ADDR_W-1:0]),
                     word_t'(in_base[q] + 4 * rd_cnt[q]));
          rd_cnt[q]++;
          if (rd_cnt[q] > job_count) report_failure("input queue read past its count");
          rd_q.push_back(req);
        end
      end
      for (int w = 0; w <= NUM_OUT; w++) begin
        if (request_write[w]) begin
          wr = write_data[w*WR_W +: WR_W];
          tag = int'(wr[TAG_W-1:0]);
          if (!available_write[w]) report_failure("write request while memory was not available");
          wr_q.push_back(tag);
          if (w == NUM_OUT) begin
            check_word("status tag", word_t'(tag), word_t'(`ACC_DSM_TAG));
            check_word("status addr", word_t'(wr[TAG_W +: ADDR_W]), word_t'(dsm_base));
            check_word("output acks before status", word_t'(out_acks), word_t'(job_count));
            dsm_count++;
            dsm_data = wr[WR_W-1 -: DATA_W];
          end else begin
            check_word("write tag", word_t'(tag), word_t'(OUT_TAG));
            check_word("write addr", word_t'(wr[TAG_W +: ADDR_W]),
                       word_t'(out_base + 4 * out_writes));
            check_word("write data", wr[WR_W-1 -: DATA_W], expected_sum(out_writes));
            out_writes++;
            if (out_writes > job_count) report_failure("more results than the configured count");
          end
        end
      end
      @(posedge clk);
      #1;
      if (rd_q.size() != 0 && rd_wait == 0) begin
        req = rd_q.pop_front();
        read_data_valid = 1'b1;
        read_queue_id = req[RQ_W-1 -: TAG_W];
        read_data = mem_word(int'(req[RQ_W-1 -: TAG_W]), int'(req[ADDR_W-1:0]));
        rd_wait = draw(stall ? 12 : 4);
      end else begin
        read_data_valid = 1'b0;
        if (rd_wait > 0) rd_wait--;
      end
      if (wr_q.size() != 0 && wr_wait == 0) begin
        tag = wr_q.pop_front();
        write_data_valid = 1'b1;
        write_queue_id = TAG_W'(tag);
        if (tag == OUT_TAG) out_acks++;
        wr_wait = draw(stall ? 10 : 3);
      end else begin
        write_data_valid = 1'b0;
        if (wr_wait > 0) wr_wait--;
      end
      for (int q = 0; q < NUM_IN; q++) available_read[q] = draw(4) != 0;
      for (int w = 0; w <= NUM_OUT; w++) begin
        available_write[w] = stall ? draw(8) == 0 : draw(4) != 0;
      end
    end
  end

  // the registered input stage shows the kind one cycle after it is driven.
  task automatic send_conf(input acc_pkg::conf_kind_e kind, input int addr, input int cnt,
                           input int qid);
    conf_valid = kind;
    conf = {ADDR_W'(addr), `ACC_QTD_WIDTH'(cnt), `ACC_QID_WIDTH'(qid)};
    @(posedge clk);
    #1;
    conf_valid = acc_pkg::conf_none;
    @(negedge clk);
    check_kind("conf_valid_reg", i_dut.conf_valid_reg, kind);
    @(posedge clk);
    #1;
  endtask

  task automatic wait_status();
    int cycles;
    cycles = 0;
    while (dsm_count == 0) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > STATUS_TIMEOUT) report_failure("timeout waiting for the status record");
    end
  endtask

  task automatic drain_memory();
    int cycles;
    cycles = 0;
    while (rd_q.size() != 0 || wr_q.size() != 0) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > DRAIN_TIMEOUT) report_failure("timeout waiting for memory responses");
    end
    repeat (10) @(posedge clk);
    #1;
  endtask

  task automatic run_job(input int b0, input int b1, input int bo, input int bd, input int cnt);
    in_base[0] = b0;
    in_base[1] = b1;
    out_base = bo;
    dsm_base = bd;
    job_count = cnt;
    rd_cnt[0] = 0;
    rd_cnt[1] = 0;
    out_writes = 0;
    out_acks = 0;
    dsm_count = 0;
    send_conf(acc_pkg::conf_input, b0, cnt, 0);
    send_conf(acc_pkg::conf_input, b1, cnt, 1);
    send_conf(acc_pkg::conf_output, bo, cnt, OUT_TAG);
    send_conf(acc_pkg::conf_dsm, bd, 0, 0);
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    wait_status();
    drain_memory();
  endtask

  task automatic test_basic_run();
    run_job('h1000, 'h2000, 'h3000, 'h3f00, 8);
    check_word("output writes", word_t'(out_writes), word_t'(8));
    check_word("output acks", word_t'(out_acks), word_t'(8));
  endtask

  task automatic test_read_requests();
    run_job('h0400, 'h0c00, 'h7000, 'h7f00, 8);
    check_word("reads of queue 0", word_t'(rd_cnt[0]), word_t'(8));
    check_word("reads of queue 1", word_t'(rd_cnt[1]), word_t'(8));
  endtask

  task automatic test_back_pressure();
    stall = 1'b1;
    run_job('h1100, 'h2100, 'h3100, 'h3e00, 8);
    stall = 1'b0;
    check_word("output writes under stall", word_t'(out_writes), word_t'(8));
  endtask

  task automatic test_status_record();
    run_job('h1200, 'h2200, 'h3200, 'h3d00, 8);
    check_word("status records", word_t'(dsm_count), word_t'(1));
    check_word("status data", dsm_data, status_word(8, 16));
  endtask

  task automatic test_restart();
    run_job('h5000, 'h5400, 'h6000, 'h6f00, 3);
    check_word("output writes after restart", word_t'(out_writes), word_t'(3));
    check_word("status records after restart", word_t'(dsm_count), word_t'(1));
    check_word("status data after restart", dsm_data, status_word(3, 6));
  endtask

  initial begin : main
    int cycles;
    start = 1'b0;
    conf_valid = acc_pkg::conf_none;
    conf = '0;
    stall = 1'b0;
    job_count = 0;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > 50) report_failure("reset was never released");
    end
    #1;
    test_basic_run();
    test_read_requests();
    test_back_pressure();
    test_status_record();
    test_restart();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset is released just after a rising edge, like every other driven input.
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- acc_1.sv
`default_nettype none
`include "acc_defs.svh"

module acc_1 (
  input  wire                                           clk,
  input  wire                                           rst_n,
  input  wire                                           start,
  input  wire acc_pkg::conf_kind_e                      conf_valid,
  input  wire [`ACC_CONF_WIDTH-1:0]                     conf,
  input  wire [`ACC_NUM_IN_QUEUES-1:0]                  available_read,
  output wire [`ACC_NUM_IN_QUEUES-1:0]                  request_read,
  output wire [(`ACC_TAG_WIDTH+`ACC_ADDR_WIDTH)*`ACC_NUM_IN_QUEUES-1:0] request_data,
  input  wire                                           read_data_valid,
  input  wire [`ACC_TAG_WIDTH-1:0]                      read_queue_id,
  input  wire [`ACC_DATA_WIDTH-1:0]                     read_data,
  input  wire [`ACC_NUM_OUT_QUEUES:0]                   available_write,
  output wire [`ACC_NUM_OUT_QUEUES:0]                   request_write,
  output wire [(`ACC_DATA_WIDTH+`ACC_ADDR_WIDTH+`ACC_TAG_WIDTH)*(`ACC_NUM_OUT_QUEUES+1)-1:0]
                                                        write_data,
  input  wire                                           write_data_valid,
  input  wire [`ACC_TAG_WIDTH-1:0]                      write_queue_id
);

  localparam int NUM_IN = `ACC_NUM_IN_QUEUES;
  localparam int NUM_OUT = `ACC_NUM_OUT_QUEUES;
  localparam int RQ_W = `ACC_TAG_WIDTH + `ACC_ADDR_WIDTH;
  localparam int WR_W = `ACC_DATA_WIDTH + `ACC_ADDR_WIDTH + `ACC_TAG_WIDTH;

  logic start_reg;
  acc_pkg::conf_kind_e conf_valid_reg;
  logic [`ACC_CONF_WIDTH-1:0] conf_reg;
  logic read_data_valid_reg;
  logic [`ACC_TAG_WIDTH-1:0] read_queue_id_reg;
  logic [`ACC_DATA_WIDTH-1:0] read_data_reg;
  logic write_data_valid_reg;
  logic [`ACC_TAG_WIDTH-1:0] write_queue_id_reg;

  wire [NUM_IN-1:0] user_available_read;
  wire [NUM_IN-1:0] user_request_read;
  wire [NUM_IN-1:0] user_read_data_valid;
  wire [NUM_IN*`ACC_DATA_WIDTH-1:0] user_read_data;
  wire [NUM_IN-1:0] input_done;
  wire [NUM_IN-1:0] has_pending_rd;
  wire user_available_write;
  wire user_request_write;
  wire [`ACC_DATA_WIDTH-1:0] user_write_data;
  wire [NUM_OUT-1:0] output_done;
  wire [NUM_OUT-1:0] has_pending_wr;
  wire user_done;
  wire user_done_dsm;

  // every registered input reaches the controllers one cycle after the port.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_reg <= 1'b0;
      conf_valid_reg <= acc_pkg::conf_none;
      read_data_valid_reg <= 1'b0;
      write_data_valid_reg <= 1'b0;
    end else begin
      start_reg <= start;
      conf_valid_reg <= conf_valid;
      read_data_valid_reg <= read_data_valid;
      write_data_valid_reg <= write_data_valid;
    end
  end

  always_ff @(posedge clk) begin
    conf_reg <= conf;
    read_queue_id_reg <= read_queue_id;
    read_data_reg <= read_data;
    write_queue_id_reg <= write_queue_id;
  end

  for (genvar q = 0; q < NUM_IN; q++) begin : gen_in_queue
    input_queue_controller #(
      .ID_QUEUE(q)
    ) i_input_queue (
      .clk                      (clk),
      .rst_n                    (rst_n),
      .start                    (start_reg),
      .conf_valid               (conf_valid_reg),
      .conf                     (conf_reg),
      .available_read           (available_read[q]),
      .read_data_valid          (read_data_valid_reg),
      .read_queue_id            (read_queue_id_reg),
      .read_data                (read_data_reg),
      .acc_user_request_read    (user_request_read[q]),
      .request_read             (request_read[q]),
      .request_data             (request_data[q*RQ_W +: RQ_W]),
      .has_rd_pending           (has_pending_rd[q]),
      .acc_user_available_read  (user_available_read[q]),
      .acc_user_read_data       (user_read_data[q*`ACC_DATA_WIDTH +: `ACC_DATA_WIDTH]),
      .acc_user_read_data_valid (user_read_data_valid[q]),
      .done                     (input_done[q])
    );
  end

  output_queue_controller #(
    .ID_QUEUE(NUM_IN)
  ) i_output_queue (
    .clk                      (clk),
    .rst_n                    (rst_n),
    .start                    (start_reg),
    .conf_valid               (conf_valid_reg),
    .conf                     (conf_reg),
    .available_write          (available_write[0]),
    .write_data_valid         (write_data_valid_reg),
    .write_queue_id           (write_queue_id_reg),
    .acc_user_request_write   (user_request_write),
    .acc_user_write_data      (user_write_data),
    .request_write            (request_write[0]),
    .write_data               (write_data[WR_W-1:0]),
    .has_wr_pending           (has_pending_wr[0]),
    .acc_user_available_write (user_available_write),
    .done                     (output_done[0])
  );

  // the status record must wait until no read or write is still open.
  assign user_done_dsm = user_done && !(|{has_pending_rd, has_pending_wr});

  dsm_controller i_dsm (
    .clk                (clk),
    .rst_n              (rst_n),
    .start              (start_reg),
    .done_rd            (input_done),
    .done_wr            (output_done),
    .done_acc           (user_done_dsm),
    .acc_req_rd_data_en (user_request_read),
    .acc_req_wr_data_en (user_request_write),
    .conf_valid         (conf_valid_reg),
    .conf               (conf_reg),
    .available_write    (available_write[NUM_OUT]),
    .write_data_valid   (write_data_valid_reg),
    .write_queue_id     (write_queue_id_reg),
    .request_write      (request_write[NUM_OUT]),
    .write_data         (write_data[NUM_OUT*WR_W +: WR_W])
  );

  acc_user_1 i_user (
    .clk                      (clk),
    .rst_n                    (rst_n),
    .start                    (start_reg),
    .acc_user_done_rd_data    (input_done),
    .acc_user_done_wr_data    (output_done),
    .acc_user_available_read  (user_available_read),
    .acc_user_read_data_valid (user_read_data_valid),
    .acc_user_read_data       (user_read_data),
    .acc_user_available_write (user_available_write),
    .acc_user_request_read    (user_request_read),
    .acc_user_request_write   (user_request_write),
    .acc_user_write_data      (user_write_data),
    .acc_user_done            (user_done)
  );

endmodule

`default_nettype wire

//--- acc_user_1.sv
`default_nettype none
`include "acc_defs.svh"

module acc_user_1 (
  input  wire                                             clk,
  input  wire                                             rst_n,
  input  wire                                             start,
  input  wire [`ACC_NUM_IN_QUEUES-1:0]                    acc_user_done_rd_data,
  input  wire [`ACC_NUM_OUT_QUEUES-1:0]                   acc_user_done_wr_data,
  input  wire [`ACC_NUM_IN_QUEUES-1:0]                    acc_user_available_read,
  input  wire [`ACC_NUM_IN_QUEUES-1:0]                    acc_user_read_data_valid,
  input  wire [`ACC_NUM_IN_QUEUES*`ACC_DATA_WIDTH-1:0]    acc_user_read_data,
  input  wire                                             acc_user_available_write,
  output logic [`ACC_NUM_IN_QUEUES-1:0]                   acc_user_request_read,
  output logic                                            acc_user_request_write,
  output logic [`ACC_DATA_WIDTH-1:0]                      acc_user_write_data,
  output logic                                            acc_user_done
);

  logic pop;
  logic [`ACC_DATA_WIDTH-1:0] sum;

  // a new pair is popped only when no sum is on its way to the output queue.
  assign pop = &acc_user_available_read && acc_user_available_write &&
               !(|acc_user_read_data_valid);
  assign acc_user_request_read = {`ACC_NUM_IN_QUEUES{pop}};

  always_comb begin
    sum = '0;
    for (int i = 0; i < `ACC_NUM_IN_QUEUES; i++) begin
      sum = sum + acc_user_read_data[i*`ACC_DATA_WIDTH +: `ACC_DATA_WIDTH];
    end
  end

  assign acc_user_request_write = &acc_user_read_data_valid;
  assign acc_user_write_data = sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_user_done <= 1'b0;
    end else if (start) begin
      acc_user_done <= 1'b0;
    end else if (&acc_user_done_rd_data && &acc_user_done_wr_data &&
                 !acc_user_request_write) begin
      acc_user_done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- dsm_controller.sv
`default_nettype none
`include "acc_defs.svh"

module dsm_controller (
  input  wire                                                      clk,
  input  wire                                                      rst_n,
  input  wire                                                      start,
  input  wire [`ACC_NUM_IN_QUEUES-1:0]                             done_rd,
  input  wire [`ACC_NUM_OUT_QUEUES-1:0]                            done_wr,
  input  wire                                                      done_acc,
  input  wire [`ACC_NUM_IN_QUEUES-1:0]                             acc_req_rd_data_en,
  input  wire [`ACC_NUM_OUT_QUEUES-1:0]                            acc_req_wr_data_en,
  input  wire acc_pkg::conf_kind_e                                 conf_valid,
  input  wire [`ACC_CONF_WIDTH-1:0]                                conf,
  input  wire                                                      available_write,
  input  wire                                                      write_data_valid,
  input  wire [`ACC_TAG_WIDTH-1:0]                                 write_queue_id,
  output logic                                                     request_write,
  output logic [`ACC_DATA_WIDTH+`ACC_ADDR_WIDTH+`ACC_TAG_WIDTH-1:0] write_data
);

  localparam int HALF = `ACC_DATA_WIDTH / 2;
  localparam logic [`ACC_TAG_WIDTH-1:0] TAG = `ACC_TAG_WIDTH'(`ACC_DSM_TAG);

  acc_pkg::dsm_state_e state;
  logic [`ACC_ADDR_WIDTH-1:0] dsm_addr;
  logic [HALF-1:0] pop_cnt;
  logic [HALF-1:0] push_cnt;
  logic [HALF-1:0] pops_now;
  logic [HALF-1:0] pushes_now;
  logic all_done;

  always_comb begin
    pops_now = '0;
    pushes_now = '0;
    for (int i = 0; i < `ACC_NUM_IN_QUEUES; i++) begin
      pops_now = pops_now + HALF'(acc_req_rd_data_en[i]);
    end
    for (int i = 0; i < `ACC_NUM_OUT_QUEUES; i++) begin
      pushes_now = pushes_now + HALF'(acc_req_wr_data_en[i]);
    end
  end

  assign all_done = done_acc && &done_rd && &done_wr;
  assign request_write = state == acc_pkg::d_write && available_write;
  assign write_data = {push_cnt, pop_cnt, dsm_addr, TAG};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= acc_pkg::d_idle;
      pop_cnt <= '0;
      push_cnt <= '0;
    end else if (start) begin
      state <= acc_pkg::d_count;
      pop_cnt <= '0;
      push_cnt <= '0;
    end else begin
      case (state)
        acc_pkg::d_count: begin
          pop_cnt <= pop_cnt + pops_now;
          push_cnt <= push_cnt + pushes_now;
          if (all_done) state <= acc_pkg::d_write;
        end
        acc_pkg::d_write: begin
          if (request_write) state <= acc_pkg::d_wait_ack;
        end
        acc_pkg::d_wait_ack: begin
          if (write_data_valid && write_queue_id == TAG) state <= acc_pkg::d_done;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (conf_valid == acc_pkg::conf_dsm) begin
      dsm_addr <= conf[`ACC_CONF_WIDTH-1 -: `ACC_ADDR_WIDTH];
    end
  end

endmodule

`default_nettype wire

//--- output_queue_controller.sv
`default_nettype none
`include "acc_defs.svh"

module output_queue_controller #(
  parameter int ID_QUEUE = 0
) (
  input  wire                                                      clk,
  input  wire                                                      rst_n,
  input  wire                                                      start,
  input  wire acc_pkg::conf_kind_e                                 conf_valid,
  input  wire [`ACC_CONF_WIDTH-1:0]                                conf,
  input  wire                                                      available_write,
  input  wire                                                      write_data_valid,
  input  wire [`ACC_TAG_WIDTH-1:0]                                 write_queue_id,
  input  wire                                                      acc_user_request_write,
  input  wire [`ACC_DATA_WIDTH-1:0]                                acc_user_write_data,
  output logic                                                     request_write,
  output logic [`ACC_DATA_WIDTH+`ACC_ADDR_WIDTH+`ACC_TAG_WIDTH-1:0] write_data,
  output logic                                                     has_wr_pending,
  output logic                                                     acc_user_available_write,
  output logic                                                     done
);

  localparam logic [`ACC_TAG_WIDTH-1:0] TAG = `ACC_TAG_WIDTH'(ID_QUEUE);
  localparam logic [`ACC_QID_WIDTH-1:0] QID = `ACC_QID_WIDTH'(ID_QUEUE);

  acc_pkg::queue_state_e state;
  logic [`ACC_ADDR_WIDTH-1:0] base;
  logic [`ACC_QTD_WIDTH-1:0] count;
  logic [`ACC_QTD_WIDTH-1:0] sent;
  logic [`ACC_QTD_WIDTH-1:0] acked;
  logic [`ACC_DATA_WIDTH-1:0] hold_data;
  logic hold_full;
  logic take;
  logic ack;

  assign take = acc_user_request_write && acc_user_available_write;
  assign ack = write_data_valid && write_queue_id == TAG;

  assign acc_user_available_write = state == acc_pkg::q_run && !hold_full;
  assign request_write = hold_full && available_write;
  // data in the high bits, then the address, then the tag.
  assign write_data = {hold_data, base + `ACC_ADDR_WIDTH'({sent, 2'b00}), TAG};
  assign has_wr_pending = sent != acked;
  assign done = state == acc_pkg::q_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= acc_pkg::q_idle;
      sent <= '0;
      acked <= '0;
      hold_full <= 1'b0;
    end else if (start) begin
      state <= acc_pkg::q_run;
      sent <= '0;
      acked <= '0;
      hold_full <= 1'b0;
    end else begin
      if (take) begin
        hold_full <= 1'b1;
      end else if (request_write) begin
        hold_full <= 1'b0;
      end
      if (request_write) sent <= sent + 1'b1;
      if (ack) acked <= acked + 1'b1;
      if (state == acc_pkg::q_run && acked == count) state <= acc_pkg::q_done;
    end
  end

  always_ff @(posedge clk) begin
    if (conf_valid == acc_pkg::conf_output && conf[`ACC_QID_WIDTH-1:0] == QID) begin
      base <= conf[`ACC_CONF_WIDTH-1 -: `ACC_ADDR_WIDTH];
      count <= conf[`ACC_QID_WIDTH +: `ACC_QTD_WIDTH];
    end
    if (take) hold_data <= acc_user_write_data;
  end

  // the user block never produces more results than the configured count.
  a_write_in_bounds: assert property (@(posedge clk) disable iff (!rst_n)
    request_write |-> sent < count);

endmodule

`default_nettype wire

//--- input_queue_controller.sv
`default_nettype none
`include "acc_defs.svh"

module input_queue_controller #(
  parameter int ID_QUEUE = 0
) (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire                                        start,
  input  wire acc_pkg::conf_kind_e                   conf_valid,
  input  wire [`ACC_CONF_WIDTH-1:0]                  conf,
  input  wire                                        available_read,
  input  wire                                        read_data_valid,
  input  wire [`ACC_TAG_WIDTH-1:0]                   read_queue_id,
  input  wire [`ACC_DATA_WIDTH-1:0]                  read_data,
  input  wire                                        acc_user_request_read,
  output logic                                       request_read,
  output logic [`ACC_TAG_WIDTH+`ACC_ADDR_WIDTH-1:0]  request_data,
  output logic                                       has_rd_pending,
  output logic                                       acc_user_available_read,
  output logic [`ACC_DATA_WIDTH-1:0]                 acc_user_read_data,
  output logic                                       acc_user_read_data_valid,
  output logic                                       done
);

  localparam int PTR_W = $clog2(`ACC_BUF_DEPTH);
  localparam logic [`ACC_TAG_WIDTH-1:0] TAG = `ACC_TAG_WIDTH'(ID_QUEUE);
  localparam logic [`ACC_QID_WIDTH-1:0] QID = `ACC_QID_WIDTH'(ID_QUEUE);

  acc_pkg::queue_state_e state;
  logic [`ACC_ADDR_WIDTH-1:0] base;
  logic [`ACC_QTD_WIDTH-1:0] count;
  logic [`ACC_QTD_WIDTH-1:0] issued;
  logic [`ACC_QTD_WIDTH-1:0] received;
  logic [`ACC_QTD_WIDTH-1:0] consumed;
  logic [`ACC_DATA_WIDTH-1:0] buffer [`ACC_BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] fill;
  logic push;
  logic pop;

  assign push = read_data_valid && read_queue_id == TAG;
  assign pop = acc_user_request_read && fill != '0;

  // words issued but not yet popped never exceed the buffer depth.
  assign request_read = state == acc_pkg::q_run && available_read && issued != count &&
                        (issued - consumed) < `ACC_QTD_WIDTH'(`ACC_BUF_DEPTH);
  assign request_data = {TAG, base + `ACC_ADDR_WIDTH'({issued, 2'b00})};
  assign has_rd_pending = issued != received;
  assign acc_user_available_read = fill != '0;
  assign done = state == acc_pkg::q_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= acc_pkg::q_idle;
      issued <= '0;
      received <= '0;
      consumed <= '0;
    end else if (start) begin
      state <= acc_pkg::q_run;
      issued <= '0;
      received <= '0;
      consumed <= '0;
    end else begin
      if (request_read) issued <= issued + 1'b1;
      if (push) received <= received + 1'b1;
      if (pop) consumed <= consumed + 1'b1;
      if (state == acc_pkg::q_run && received == count && consumed == count) begin
        state <= acc_pkg::q_done;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
      acc_user_read_data_valid <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !push) begin
        fill <= fill - 1'b1;
      end
      acc_user_read_data_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (conf_valid == acc_pkg::conf_input && conf[`ACC_QID_WIDTH-1:0] == QID) begin
      base <= conf[`ACC_CONF_WIDTH-1 -: `ACC_ADDR_WIDTH];
      count <= conf[`ACC_QID_WIDTH +: `ACC_QTD_WIDTH];
    end
    if (push) buffer[wr_ptr] <= read_data;
    if (pop) acc_user_read_data <= buffer[rd_ptr];
  end

  // memory must only answer reads this queue has actually issued.
  a_no_orphan_response: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> has_rd_pending);

endmodule

`default_nettype wire

//--- acc_pkg.sv
`default_nettype none

package acc_pkg;

  // meaning of conf_valid for the word on conf.
  typedef enum logic [1:0] {
    conf_none   = 2'd0,
    conf_input  = 2'd1,
    conf_output = 2'd2,
    conf_dsm    = 2'd3
  } conf_kind_e;

  typedef enum logic [1:0] {
    q_idle,
    q_run,
    q_done
  } queue_state_e;

  typedef enum logic [2:0] {
    d_idle,
    d_count,
    d_write,
    d_wait_ack,
    d_done
  } dsm_state_e;

endpackage

`default_nettype wire

//--- acc_defs.svh
`ifndef ACC_DEFS_SVH
`define ACC_DEFS_SVH

`define ACC_ADDR_WIDTH      16
`define ACC_QTD_WIDTH       16
`define ACC_DATA_WIDTH      32
`define ACC_TAG_WIDTH       4
`define ACC_QID_WIDTH       4

// address, count and queue id, from high bits to low bits.
`define ACC_CONF_WIDTH      (`ACC_ADDR_WIDTH + `ACC_QTD_WIDTH + `ACC_QID_WIDTH)

`define ACC_NUM_IN_QUEUES   2
`define ACC_NUM_OUT_QUEUES  1
`define ACC_DSM_TAG         15
`define ACC_BUF_DEPTH       4

`endif
